//--- hdl/heap_consts.svh
// heap geometry, widths and FIFO depth; include wherever these constants are needed
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

// byte address and size width
`define HEAP_ADDR_W 16

`define HEAP_BYTES 1024
`define HEAP_BASE 8  // first real block, dummy head sits at 0

`define BLOCK_HEADER_SIZE 8
`define ALLOC_GRAIN 8  // also the header RAM word stride
`define MIN_ALLOC_SIZE 16

// header RAM index, HEAP_BYTES / ALLOC_GRAIN entries
`define HDR_IDX_W 7

// request FIFO entries, equal to the credits the intake starts with
`define REQ_FIFO_DEPTH 4

`endif

//--- hdl/heap_pkg.sv
// shared types of the heap allocator; compile before the RTL, use through heap_pkg::
`default_nettype none

`include "heap_consts.svh"

package heap_pkg;

  typedef logic [`HEAP_ADDR_W-1:0] heap_addr_t;  // byte address or size
  typedef logic [`HDR_IDX_W-1:0] hdr_idx_t;  // address / ALLOC_GRAIN

  typedef enum logic {
    FIRST_FIT = 1'b0,
    BEST_FIT  = 1'b1
  } alloc_strategy_e;

  typedef enum logic [3:0] {
    ST_INIT_HEAD,
    ST_INIT_BLOCK,
    ST_IDLE,
    ST_ALLOC_WALK,
    ST_ALLOC_FIT,
    ST_WR_NEW,
    ST_FREE_WALK,
    ST_FREE_LINK,
    ST_WR_LINK,
    ST_RSP
  } walker_state_e;

  typedef struct packed {
    heap_addr_t size;
    heap_addr_t next;  // 0 ends the list
  } block_header_t;

  typedef struct packed {
    logic       is_alloc;
    heap_addr_t operand;  // size on alloc, pointer on free
  } heap_req_t;

  typedef struct packed {
    logic       is_alloc;
    logic       ok;
    heap_addr_t ptr;
  } heap_rsp_t;

  typedef struct packed {
    logic          en;
    hdr_idx_t      idx;
    block_header_t hdr;
  } hdr_wr_t;

endpackage

`default_nettype wire

//--- hdl/heap_req_intake.sv
// request intake: takes valid/ready requests, normalizes alloc sizes, pushes on credits
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_req_intake (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_valid_i,
  input  wire heap_pkg::heap_req_t req_i,
  output logic                     req_ready_o,
  output logic                     push_o,
  output heap_pkg::heap_req_t      push_req_o,
  input  wire logic                credit_i
);

  localparam int CRED_W = $clog2(`REQ_FIFO_DEPTH + 1);
  localparam heap_pkg::heap_addr_t GRAIN_M1 = heap_pkg::heap_addr_t'(`ALLOC_GRAIN - 1);
  localparam heap_pkg::heap_addr_t MIN_SZ = heap_pkg::heap_addr_t'(`MIN_ALLOC_SIZE);

  logic [CRED_W-1:0]    credit_q, credit_d;
  logic                 push_q, push_d;
  logic                 ready_q;
  heap_pkg::heap_addr_t size_rnd;
  heap_pkg::heap_req_t  req_norm;
  heap_pkg::heap_req_t  push_req_q;

  assign size_rnd = (req_i.operand + GRAIN_M1) & ~GRAIN_M1;  // round up to grain

  always_comb begin
    req_norm = req_i;  // free pointer passes as is
    if (req_i.is_alloc) begin
      req_norm.operand = (size_rnd < MIN_SZ) ? MIN_SZ : size_rnd;
    end
  end

  assign push_d   = req_valid_i && ready_q;
  assign credit_d = credit_q - {{(CRED_W-1){1'b0}}, push_q} + {{(CRED_W-1){1'b0}}, credit_i};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      credit_q <= CRED_W'(`REQ_FIFO_DEPTH);
      push_q   <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      credit_q <= credit_d;
      push_q   <= push_d;
      // ready next cycle only if a credit is left beyond the pending push
      ready_q  <= credit_d > {{(CRED_W-1){1'b0}}, push_d};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_d) push_req_q <= req_norm;
  end

  assign req_ready_o = ready_q;
  assign push_o      = push_q;
  assign push_req_o  = push_req_q;

endmodule

`default_nettype wire

//--- hdl/heap_req_fifo.sv
// request FIFO between intake and walker; each pop returns one credit to the intake
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_req_fifo (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                push_i,
  input  wire heap_pkg::heap_req_t push_req_i,
  output logic                     head_valid_o,
  output heap_pkg::heap_req_t      head_req_o,
  input  wire logic                pop_i,
  output logic                     credit_o
);

  localparam int DEPTH = `REQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  heap_pkg::heap_req_t mem_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                credit_q;
  logic                do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_pop = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);  // credits keep this from overflowing
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      credit_q <= do_pop;  // one pulse per pop
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_req_i;
  end

  assign head_valid_o = (count_q != '0);
  assign head_req_o   = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

endmodule

`default_nettype wire

//--- hdl/heap_header_ram.sv
// block header storage; one registered read port, one write port, read returns old data
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_header_ram (
  input  wire logic                    clk_i,
  input  wire heap_pkg::hdr_idx_t      rd_idx_i,
  output heap_pkg::block_header_t      rd_hdr_o,
  input  wire heap_pkg::hdr_wr_t       hdr_wr_i
);

  localparam int ENTRIES = `HEAP_BYTES / `ALLOC_GRAIN;

  heap_pkg::block_header_t mem_q [ENTRIES];
  heap_pkg::block_header_t rd_hdr_q;

  // write port
  always_ff @(posedge clk_i) begin
    if (hdr_wr_i.en) begin
      mem_q[hdr_wr_i.idx] <= hdr_wr_i.hdr;
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_i) begin
    rd_hdr_q <= mem_q[rd_idx_i];  // same-cycle write not visible yet
  end

  assign rd_hdr_o = rd_hdr_q;

endmodule

`default_nettype wire

//--- hdl/heap_free_list_walker.sv
// free-list walker FSM: builds the initial heap, then serves alloc and free one at a time
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_free_list_walker (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire heap_pkg::alloc_strategy_e strategy_i,
  input  wire logic                      head_valid_i,
  input  wire heap_pkg::heap_req_t       head_req_i,
  output logic                           pop_o,
  output heap_pkg::hdr_idx_t             rd_idx_o,
  input  wire heap_pkg::block_header_t   rd_hdr_i,
  output heap_pkg::hdr_wr_t              hdr_wr_o,
  output logic                           rsp_valid_o,
  output heap_pkg::heap_rsp_t            rsp_o,
  input  wire logic                      rsp_ready_i
);

  localparam heap_pkg::heap_addr_t HDR_SZ = heap_pkg::heap_addr_t'(`BLOCK_HEADER_SIZE);
  localparam heap_pkg::heap_addr_t MIN_SZ = heap_pkg::heap_addr_t'(`MIN_ALLOC_SIZE);
  localparam heap_pkg::heap_addr_t BASE = heap_pkg::heap_addr_t'(`HEAP_BASE);
  localparam heap_pkg::heap_addr_t INIT_SZ =
    heap_pkg::heap_addr_t'(`HEAP_BYTES - `HEAP_BASE - `BLOCK_HEADER_SIZE);

  heap_pkg::walker_state_e state_q, state_d;
  heap_pkg::heap_req_t     req_q, req_d;
  heap_pkg::heap_rsp_t     rsp_q, rsp_d;
  heap_pkg::heap_addr_t    cur_addr_q, cur_addr_d;  // header arriving on rd_hdr_i
  heap_pkg::heap_addr_t    prev_addr_q, prev_addr_d;
  heap_pkg::block_header_t prev_hdr_q, prev_hdr_d;
  heap_pkg::heap_addr_t    fit_addr_q, fit_addr_d;
  heap_pkg::block_header_t fit_hdr_q, fit_hdr_d;
  heap_pkg::heap_addr_t    best_diff_q, best_diff_d;
  logic                    found_q, found_d;
  heap_pkg::heap_addr_t    link_addr_q, link_addr_d;  // header whose next gets patched
  heap_pkg::block_header_t link_hdr_q, link_hdr_d;
  heap_pkg::heap_addr_t    link_next_q, link_next_d;

  heap_pkg::heap_addr_t    rd_addr;
  heap_pkg::heap_addr_t    cur_diff;
  logic                    cur_fits, cur_take;
  logic [`HEAP_ADDR_W:0]   split_need;
  logic                    do_split;
  heap_pkg::heap_addr_t    blk_addr, new_addr;

  function automatic heap_pkg::hdr_idx_t addr2idx(input heap_pkg::heap_addr_t a);
    return heap_pkg::hdr_idx_t'(a / `ALLOC_GRAIN);
  endfunction

  assign cur_fits = rd_hdr_i.size >= req_q.operand;
  assign cur_diff = rd_hdr_i.size - req_q.operand;
  // first-fit takes any fit, best-fit only a tighter one
  assign cur_take = cur_fits && (strategy_i == heap_pkg::FIRST_FIT || !found_q ||
                                 cur_diff < best_diff_q);

  assign split_need = {1'b0, req_q.operand} + {1'b0, HDR_SZ} + {1'b0, MIN_SZ};
  assign do_split   = {1'b0, fit_hdr_q.size} >= split_need;
  assign new_addr   = fit_addr_q + HDR_SZ + req_q.operand;
  assign blk_addr   = req_q.operand - HDR_SZ;

  always_comb begin
    state_d     = state_q;
    req_d       = req_q;
    rsp_d       = rsp_q;
    cur_addr_d  = cur_addr_q;
    prev_addr_d = prev_addr_q;
    prev_hdr_d  = prev_hdr_q;
    fit_addr_d  = fit_addr_q;
    fit_hdr_d   = fit_hdr_q;
    best_diff_d = best_diff_q;
    found_d     = found_q;
    link_addr_d = link_addr_q;
    link_hdr_d  = link_hdr_q;
    link_next_d = link_next_q;
    pop_o       = 1'b0;
    rd_addr     = '0;
    hdr_wr_o    = '0;
    rsp_valid_o = 1'b0;

    unique case (state_q)
      heap_pkg::ST_INIT_HEAD: begin
        hdr_wr_o.en       = 1'b1;  // dummy head, size 0
        hdr_wr_o.idx      = addr2idx('0);
        hdr_wr_o.hdr.next = BASE;
        state_d           = heap_pkg::ST_INIT_BLOCK;
      end
      heap_pkg::ST_INIT_BLOCK: begin
        hdr_wr_o.en       = 1'b1;  // one block spanning the heap
        hdr_wr_o.idx      = addr2idx(BASE);
        hdr_wr_o.hdr.size = INIT_SZ;
        state_d           = heap_pkg::ST_IDLE;
      end
      heap_pkg::ST_IDLE: begin
        if (head_valid_i) begin
          pop_o      = 1'b1;
          req_d      = head_req_i;
          cur_addr_d = '0;
          found_d    = 1'b0;
          rd_addr    = '0;  // walk always starts at the head
          state_d    = head_req_i.is_alloc ? heap_pkg::ST_ALLOC_WALK : heap_pkg::ST_FREE_WALK;
        end
      end
      heap_pkg::ST_ALLOC_WALK: begin
        if (cur_take) begin
          fit_addr_d  = cur_addr_q;
          fit_hdr_d   = rd_hdr_i;
          link_addr_d = prev_addr_q;
          link_hdr_d  = prev_hdr_q;
          best_diff_d = cur_diff;
          found_d     = 1'b1;
        end
        if ((strategy_i == heap_pkg::FIRST_FIT && cur_fits) || rd_hdr_i.next == '0) begin
          if (found_q || cur_take) begin
            state_d = heap_pkg::ST_ALLOC_FIT;
          end else begin
            rsp_d.is_alloc = 1'b1;  // nothing fits
            rsp_d.ok       = 1'b0;
            rsp_d.ptr      = '0;
            state_d        = heap_pkg::ST_RSP;
          end
        end else begin
          prev_addr_d = cur_addr_q;
          prev_hdr_d  = rd_hdr_i;
          cur_addr_d  = rd_hdr_i.next;
          rd_addr     = rd_hdr_i.next;
        end
      end
      heap_pkg::ST_ALLOC_FIT: begin
        rsp_d.is_alloc = 1'b1;
        rsp_d.ok       = 1'b1;
        rsp_d.ptr      = fit_addr_q + HDR_SZ;
        if (do_split) begin
          hdr_wr_o.en       = 1'b1;  // shrink the allocated block
          hdr_wr_o.idx      = addr2idx(fit_addr_q);
          hdr_wr_o.hdr.size = req_q.operand;
          link_next_d       = new_addr;
          state_d           = heap_pkg::ST_WR_NEW;
        end else begin
          link_next_d = fit_hdr_q.next;  // whole block leaves the list
          state_d     = heap_pkg::ST_WR_LINK;
        end
      end
      heap_pkg::ST_WR_NEW: begin
        hdr_wr_o.en       = 1'b1;  // remainder becomes a free block
        hdr_wr_o.idx      = addr2idx(new_addr);
        hdr_wr_o.hdr.size = fit_hdr_q.size - req_q.operand - HDR_SZ;
        hdr_wr_o.hdr.next = fit_hdr_q.next;
        state_d           = heap_pkg::ST_WR_LINK;
      end
      heap_pkg::ST_FREE_WALK: begin
        if (rd_hdr_i.next != '0 && rd_hdr_i.next < blk_addr) begin
          cur_addr_d = rd_hdr_i.next;
          rd_addr    = rd_hdr_i.next;
        end else begin
          link_addr_d = cur_addr_q;  // insert after this one
          link_hdr_d  = rd_hdr_i;
          link_next_d = blk_addr;
          rd_addr     = blk_addr;  // fetch the stored size
          state_d     = heap_pkg::ST_FREE_LINK;
        end
      end
      heap_pkg::ST_FREE_LINK: begin
        hdr_wr_o.en       = 1'b1;
        hdr_wr_o.idx      = addr2idx(blk_addr);
        hdr_wr_o.hdr.size = rd_hdr_i.size;
        hdr_wr_o.hdr.next = link_hdr_q.next;
        rsp_d.is_alloc    = 1'b0;
        rsp_d.ok          = 1'b1;
        rsp_d.ptr         = '0;
        state_d           = heap_pkg::ST_WR_LINK;
      end
      heap_pkg::ST_WR_LINK: begin
        hdr_wr_o.en       = 1'b1;
        hdr_wr_o.idx      = addr2idx(link_addr_q);
        hdr_wr_o.hdr.size = link_hdr_q.size;
        hdr_wr_o.hdr.next = link_next_q;
        state_d           = heap_pkg::ST_RSP;
      end
      heap_pkg::ST_RSP: begin
        rsp_valid_o = 1'b1;  // held until taken
        if (rsp_ready_i) state_d = heap_pkg::ST_IDLE;
      end
      default: state_d = heap_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= heap_pkg::ST_INIT_HEAD;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q       <= req_d;
    rsp_q       <= rsp_d;
    cur_addr_q  <= cur_addr_d;
    prev_addr_q <= prev_addr_d;
    prev_hdr_q  <= prev_hdr_d;
    fit_addr_q  <= fit_addr_d;
    fit_hdr_q   <= fit_hdr_d;
    best_diff_q <= best_diff_d;
    found_q     <= found_d;
    link_addr_q <= link_addr_d;
    link_hdr_q  <= link_hdr_d;
    link_next_q <= link_next_d;
  end

  assign rd_idx_o = addr2idx(rd_addr);
  assign rsp_o    = rsp_q;

endmodule

`default_nettype wire

//--- hdl/heap_alloc_top.sv
// heap allocator top: intake, credit FIFO, free-list walker and header RAM
`timescale 1ns/1ps
`default_nettype none

module heap_alloc_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire heap_pkg::alloc_strategy_e strategy_i,
  input  wire logic                      req_valid_i,
  input  wire heap_pkg::heap_req_t       req_i,
  output logic                           req_ready_o,
  output logic                           rsp_valid_o,
  output heap_pkg::heap_rsp_t            rsp_o,
  input  wire logic                      rsp_ready_i
);

  logic                    push;
  heap_pkg::heap_req_t     push_req;
  logic                    credit;
  logic                    head_valid;
  heap_pkg::heap_req_t     head_req;
  logic                    pop;
  heap_pkg::hdr_idx_t      rd_idx;
  heap_pkg::block_header_t rd_hdr;
  heap_pkg::hdr_wr_t       hdr_wr;

  heap_req_intake heap_req_intake_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .push_o      (push),
    .push_req_o  (push_req),
    .credit_i    (credit)
  );

  heap_req_fifo heap_req_fifo_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_req_i   (push_req),
    .head_valid_o (head_valid),
    .head_req_o   (head_req),
    .pop_i        (pop),
    .credit_o     (credit)
  );

  heap_free_list_walker heap_free_list_walker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .strategy_i   (strategy_i),
    .head_valid_i (head_valid),
    .head_req_i   (head_req),
    .pop_o        (pop),
    .rd_idx_o     (rd_idx),
    .rd_hdr_i     (rd_hdr),
    .hdr_wr_o     (hdr_wr),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .rsp_ready_i  (rsp_ready_i)
  );

  heap_header_ram heap_header_ram_i (
    .clk_i    (clk_i),
    .rd_idx_i (rd_idx),
    .rd_hdr_o (rd_hdr),
    .hdr_wr_i (hdr_wr)
  );

endmodule

`default_nettype wire

//--- tests/tb_heap_alloc.sv
// heap allocator testbench; replays tests/heap_testdata.txt and checks responses in order
`timescale 1ns/1ps
`default_nettype none

module tb_heap_alloc;

  localparam int MAX_VECS = 64;
  localparam int WAIT_LIMIT = 2000;  // cycles per wait
  localparam int LONG_STALL = 60;
  localparam string DATA_FILE = "tests/heap_testdata.txt";

  logic                      clk;
  logic                      rst_n;
  heap_pkg::alloc_strategy_e strategy;
  logic                      req_valid;
  heap_pkg::heap_req_t       req;
  logic                      req_ready;
  logic                      rsp_valid;
  heap_pkg::heap_rsp_t       rsp;
  logic                      rsp_ready;

  heap_pkg::alloc_strategy_e strat_v [MAX_VECS];
  logic                      alloc_v [MAX_VECS];
  heap_pkg::heap_addr_t      operand_v [MAX_VECS];
  logic                      ok_v [MAX_VECS];
  heap_pkg::heap_addr_t      ptr_v [MAX_VECS];

  int   num_vecs;
  int   err_cnt;
  int   timeout_cnt;
  int   rsp_cnt;  // responses taken by the checker
  logic aborted;
  int   seed = 7026;
  int   xfer_cnt = 0;
  int   bp_cycles = 0;

  heap_alloc_top heap_alloc_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .strategy_i  (strategy),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // transfers and back-pressure seen on the ports
  always @(negedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) xfer_cnt++;
    if (rst_n && req_valid && !req_ready && rsp_valid && !rsp_ready) bp_cycles++;
  end

  task automatic load_vectors();
    int    fd;
    int    r;
    int    n;
    int    s;
    int    op;
    int    opnd;
    int    ok;
    int    ptr;
    string line;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open test data file %s", DATA_FILE);
      err_cnt++;
      return;
    end
    while (!$feof(fd) && num_vecs < MAX_VECS) begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %d %d %d %d", s, op, opnd, ok, ptr);
      if (n != 5) begin
        $display("malformed test data line: %s", line);
        err_cnt++;
        continue;
      end
      strat_v[num_vecs]   = (s != 0) ? heap_pkg::BEST_FIT : heap_pkg::FIRST_FIT;
      alloc_v[num_vecs]   = (op != 0);
      operand_v[num_vecs] = heap_pkg::heap_addr_t'(opnd);
      ok_v[num_vecs]      = (ok != 0);
      ptr_v[num_vecs]     = heap_pkg::heap_addr_t'(ptr);
      num_vecs++;
    end
    $fclose(fd);
  endtask

  task automatic drive_requests();
    int idx;
    int t;
    int gap;
    for (idx = 0; idx < num_vecs; idx++) begin
      if (aborted) break;
      // strategy switch only with nothing in flight
      if (idx > 0 && strat_v[idx] != strat_v[idx-1]) begin
        t = 0;
        while (rsp_cnt < idx && t < WAIT_LIMIT && !aborted) begin
          @(negedge clk);
          t++;
        end
        if (rsp_cnt < idx) begin
          if (!aborted) begin
            $display("timeout: responses before strategy switch at request %0d never came", idx);
            timeout_cnt++;
          end
          aborted = 1'b1;
          break;
        end
      end
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      strategy     <= strat_v[idx];
      req_valid    <= 1'b1;
      req.is_alloc <= alloc_v[idx];
      req.operand  <= operand_v[idx];
      t = 0;
      do begin
        @(negedge clk);
        t++;
      end while (!req_ready && t < WAIT_LIMIT);
      if (!req_ready) begin
        $display("timeout: request %0d was never accepted", idx);
        timeout_cnt++;
        aborted = 1'b1;
        break;
      end
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  task automatic check_responses();
    int idx;
    int t;
    int stall;
    for (idx = 0; idx < num_vecs; idx++) begin
      if (aborted) break;
      t = 0;
      do begin
        @(negedge clk);
        t++;
      end while (!rsp_valid && t < WAIT_LIMIT);
      if (!rsp_valid) begin
        $display("timeout: no response for request %0d", idx);
        timeout_cnt++;
        aborted = 1'b1;
        break;
      end
      // long hold after a strategy switch lets the FIFO fill up
      if (idx == 0 || strat_v[idx] != strat_v[idx-1]) stall = LONG_STALL;
      else stall = $unsigned($random(seed)) % 4;
      repeat (stall) @(posedge clk);
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(negedge clk);
      assert (rsp_valid) else begin
        err_cnt++;
        $display("ERROR at %0t: response %0d dropped while held", $time, idx);
      end
      assert (rsp.is_alloc == alloc_v[idx] && rsp.ok == ok_v[idx] && rsp.ptr == ptr_v[idx])
      else begin
        err_cnt++;
        $display("ERROR at %0t: response %0d is_alloc %0b ok %0b ptr %0d, expected %0b %0b %0d",
                 $time, idx, rsp.is_alloc, rsp.ok, rsp.ptr, alloc_v[idx], ok_v[idx], ptr_v[idx]);
      end
      @(posedge clk);
      rsp_ready <= 1'b0;
      rsp_cnt++;
    end
  endtask

  initial begin
    logic stray;
    rst_n       = 1'b0;
    strategy    = heap_pkg::FIRST_FIT;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b0;
    num_vecs    = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    rsp_cnt     = 0;
    aborted     = 1'b0;
    stray       = 1'b0;
    load_vectors();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    fork
      drive_requests();
      check_responses();
    join

    // nothing may follow the last response
    repeat (20) begin
      @(negedge clk);
      if (rsp_valid) stray = 1'b1;
    end
    assert (!stray) else begin
      err_cnt++;
      $display("ERROR at %0t: response without a matching request", $time);
    end
    assert (num_vecs > 0 && xfer_cnt == num_vecs) else begin
      err_cnt++;
      $display("ERROR at %0t: %0d responses for %0d requests", $time, xfer_cnt, num_vecs);
    end
    assert (bp_cycles > 0) else begin
      err_cnt++;
      $display("ERROR at %0t: req_ready_o never dropped while responses stalled", $time);
    end

    $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/heap_pkg.sv
hdl/heap_req_intake.sv
hdl/heap_req_fifo.sv
hdl/heap_header_ram.sv
hdl/heap_free_list_walker.sv
hdl/heap_alloc_top.sv
tests/tb_heap_alloc.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the heap allocator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module tb_heap_alloc -Mdir obj_dir
./obj_dir/Vtb_heap_alloc | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

//--- tests/heap_testdata.txt
# strategy (0 first-fit, 1 best-fit)  op (1 alloc, 0 free)  operand  expected_ok  expected_ptr
# operand is the requested size for alloc and the pointer for free; all values decimal
0 1 10 1 16
0 1 24 1 40
0 1 40 1 72
0 0 40 1 0
0 1 24 1 40
0 1 100 1 120
0 1 16 1 232
0 1 32 1 256
0 1 16 1 296
0 0 120 1 0
0 0 256 1 0
1 1 32 1 256
0 1 32 1 120
0 1 800 0 0
0 1 64 1 160
0 1 690 1 320
0 1 690 0 0
0 0 320 1 0
0 1 16 1 320
0 1 16 1 344
0 1 16 1 368
0 1 16 1 392
0 0 344 1 0
0 0 368 1 0
0 1 8 1 344
0 1 16 1 368
0 1 0 1 416
